// ==== flist.f ====
hdl/lockstep_pkg.sv
hdl/lockstep_delay.sv
hdl/shadow_rst_seq.sv
hdl/mini_core.sv
hdl/lockstep_compare.sv
hdl/lockstep_top.sv
verif/tb_lockstep.sv

// ==== verif/lockstep_stimulus.txt ====
// instr_valid instr main_wb_valid main_wb_addr main_wb_data expected_alert
// Main outputs trail their instruction by two lines, alerts trail a corruption by three
0 0000 1 2 BEEF 0
0 0000 1 1 0055 0
0 0000 0 0 1234 0
1 6523 0 0 0000 0
1 68F0 0 0 0000 0
1 1D80 1 1 0123 0
1 2340 1 2 00F0 0
1 34C0 1 3 0213 0
1 49C0 1 0 00F0 0
1 5BFF 1 1 02E3 0
1 6FFF 1 2 0203 0
1 51FF 1 2 0202 0
1 0ABC 1 3 03FF 0
1 F123 1 0 02EF 0
0 0000 0 0 0000 0
0 0000 0 0 0000 0
0 0000 0 0 0000 0
1 3FC0 0 0 0000 0
1 1C40 0 0 0000 0
1 2500 1 3 0000 0
0 0000 1 3 05D3 0
0 0000 1 1 FFF4 0
0 0000 0 0 0000 0
0 0000 0 0 0000 1
0 0000 0 0 0000 0
1 62AA 0 0 0000 0
1 48C0 0 0 0000 0
1 540C 1 1 02AA 0
0 0000 1 2 0082 0
0 0000 1 1 0000 0
0 0000 0 0 0000 1
0 0000 0 0 0000 0
0 0000 0 0 0000 0
0 0000 1 0 0000 0
0 0000 0 0 0000 0
0 0000 0 0 0000 0
0 0000 0 0 0000 1
1 6C01 0 0 0000 0
0 0000 0 0 0000 0
0 0000 0 3 0001 0
0 0000 0 0 0000 0
0 0000 0 0 0000 0
0 0000 0 0 0000 1
0 1D80 0 0 0000 0
0 FFFF 0 0 0000 0
0 5BFF 0 0 0000 0
0 0000 0 0 0000 0
1 13C0 0 0 0000 0
1 10C0 0 0 0000 0
1 1000 1 0 0002 0
1 2500 1 0 0003 0
1 3980 1 0 0006 0
1 5A00 1 1 FFFA 0
1 4E40 1 2 FF78 0
1 7000 1 2 FD78 0
1 6555 1 3 FD78 0
0 0000 0 0 0000 0
0 0000 1 1 0154 0
0 0000 0 0 0000 0
0 0000 0 0 0000 0
0 0000 0 0 0000 1
0 0000 0 0 0000 0
0 0000 0 0 0000 0
0 0000 0 0 0000 0
0 0000 0 0 0000 0
0 0000 0 0 0000 0
0 0000 0 0 0000 0
0 0000 0 0 0000 0
0 0000 0 0 0000 0
0 0000 0 0 0000 0
0 0000 0 0 0000 0
0 0000 0 0 0000 0
0 0000 0 0 0000 0
0 0000 0 0 0000 0
0 0000 0 0 0000 0
0 0000 0 0 0000 0

// ==== verif/tb_lockstep.sv ====
/*
  Testbench of the lockstep checker
  Replays the per-cycle stimulus file and checks the major alert
*/
`timescale 1ns/1ps
`default_nettype none

module tb_lockstep;

  localparam int CLK_PERIOD   = 8;
  localparam int RST_CYCLES   = 8;
  localparam int NUM_LINES    = 76;
  localparam int MAX_LINES    = 256;
  localparam int MAX_GAP      = 3;
  // Stimulus line on which rst_ni is released
  localparam int RELEASE_LINE = 3;
  localparam int WATCHDOG_NS  = 2 * NUM_LINES * CLK_PERIOD
                                + (RST_CYCLES + MAX_GAP + 1) * CLK_PERIOD;

  logic                                clk_i;
  logic                                rst_ni;
  logic                                instr_valid_i;
  logic [lockstep_pkg::INSTR_W-1:0]    instr_i;
  logic                                main_wb_valid_i;
  logic [lockstep_pkg::REG_ADDR_W-1:0] main_wb_addr_i;
  logic [lockstep_pkg::XLEN-1:0]       main_wb_data_i;
  logic                                alert_major_o;

  lockstep_top DUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .main_wb_valid_i(main_wb_valid_i),
    .main_wb_addr_i (main_wb_addr_i),
    .main_wb_data_i (main_wb_data_i),
    .alert_major_o  (alert_major_o)
  );

  initial begin
    clk_i = 1'b0;
  end

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  ///////////////////////////////////////////////////////////////////////
  // Stimulus storage

  logic                                stim_valid [MAX_LINES];
  logic [lockstep_pkg::INSTR_W-1:0]    stim_instr [MAX_LINES];
  logic                                stim_wb_valid [MAX_LINES];
  logic [lockstep_pkg::REG_ADDR_W-1:0] stim_wb_addr [MAX_LINES];
  logic [lockstep_pkg::XLEN-1:0]       stim_wb_data [MAX_LINES];
  logic                                stim_alert [MAX_LINES];
  int                                  line_count;
  int                                  seed;

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s got %0h, expected %0h",
               $time, name, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "check failed");
    end
  endtask

  task automatic load_stimulus();
    int    fd;
    int    n;
    string line;
    logic [3:0]  f_valid;
    logic [15:0] f_instr;
    logic [3:0]  f_wb_valid;
    logic [3:0]  f_wb_addr;
    logic [15:0] f_wb_data;
    logic [3:0]  f_alert;
    line_count = 0;
    fd = $fopen("verif/lockstep_stimulus.txt", "r");
    if (fd == 0) begin
      stop_with_failure("Could not open the stimulus file verif/lockstep_stimulus.txt");
    end
    while (!$feof(fd) && line_count < MAX_LINES) begin
      line = "";
      void'($fgets(line, fd));
      // Skip comment and empty lines
      if (line.len() > 0 && line.getc(0) != "/") begin
        n = $sscanf(line, "%h %h %h %h %h %h", f_valid, f_instr, f_wb_valid,
                    f_wb_addr, f_wb_data, f_alert);
        if (n == 6) begin
          stim_valid[line_count]    = f_valid[0];
          stim_instr[line_count]    = f_instr;
          stim_wb_valid[line_count] = f_wb_valid[0];
          stim_wb_addr[line_count]  = f_wb_addr[1:0];
          stim_wb_data[line_count]  = f_wb_data;
          stim_alert[line_count]    = f_alert[0];
          line_count++;
        end else if (n > 0) begin
          stop_with_failure("A stimulus line does not hold six hex fields");
        end
      end
    end
    $fclose(fd);
    if (line_count < NUM_LINES) begin
      stop_with_failure("The stimulus file holds fewer lines than the test needs");
    end
  endtask

  task automatic drive_idle();
    instr_valid_i   = 1'b0;
    instr_i         = '0;
    main_wb_valid_i = 1'b0;
    main_wb_addr_i  = '0;
    main_wb_data_i  = '0;
  endtask

  ///////////////////////////////////////////////////////////////////////
  // Watchdog

  initial begin
    #(WATCHDOG_NS * 1ns);
    $display("Timeout: the replay did not finish in time");
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

  ///////////////////////////////////////////////////////////////////////
  // Replay

  initial begin
    int gap;
    seed        = 98674;
    rst_ni      = 1'b1;
    drive_idle();
    load_stimulus();

    gap = $unsigned($random(seed)) % (MAX_GAP + 1);
    repeat (gap) @(negedge clk_i);

    @(negedge clk_i);
    rst_ni = 1'b0;
    // Replay starts three lines before the release
    repeat (RST_CYCLES - RELEASE_LINE) @(negedge clk_i);

    for (int m = 0; m < NUM_LINES; m++) begin
      // Alert of the cycle after the previous rising edge
      check_value("alert_major_o", {31'b0, alert_major_o}, {31'b0, stim_alert[m]});
      instr_valid_i   = stim_valid[m];
      instr_i         = stim_instr[m];
      main_wb_valid_i = stim_wb_valid[m];
      main_wb_addr_i  = stim_wb_addr[m];
      main_wb_data_i  = stim_wb_data[m];
      if (m == RELEASE_LINE) begin
        rst_ni = 1'b1;
      end
      @(negedge clk_i);
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/lockstep_top.sv ====
/*
  Lockstep checker top level
  Reset sequencer, input and output delays, shadow core, comparator
*/
`timescale 1ns/1ps
`default_nettype none

module lockstep_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                instr_valid_i,
  input  logic [lockstep_pkg::INSTR_W-1:0]    instr_i,
  input  logic                                main_wb_valid_i,
  input  logic [lockstep_pkg::REG_ADDR_W-1:0] main_wb_addr_i,
  input  logic [lockstep_pkg::XLEN-1:0]       main_wb_data_i,
  output logic                                alert_major_o
);

  logic rst_shadow_n;
  logic cmp_en;

  shadow_rst_seq u_rst_seq (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rst_shadow_no(rst_shadow_n),
    .cmp_en_o     (cmp_en)
  );

  ////////////////////////////////////////////////////////////////////
  // Shadow core inputs, delayed by the offset

  logic [lockstep_pkg::INSTR_W:0]   in_word;
  logic [lockstep_pkg::INSTR_W:0]   shadow_in_word;
  logic                             shadow_instr_valid;
  logic [lockstep_pkg::INSTR_W-1:0] shadow_instr;

  assign in_word = {instr_valid_i, instr_i};

  lockstep_delay #(
    .Width(1 + lockstep_pkg::INSTR_W),
    .Depth(lockstep_pkg::LOCKSTEP_OFFSET)
  ) u_in_delay (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .data_i(in_word),
    .data_o(shadow_in_word)
  );

  assign {shadow_instr_valid, shadow_instr} = shadow_in_word;

  logic                                shadow_wb_valid;
  logic [lockstep_pkg::REG_ADDR_W-1:0] shadow_wb_addr;
  logic [lockstep_pkg::XLEN-1:0]       shadow_wb_data;

  mini_core u_shadow_core (
    .clk_i        (clk_i),
    .rst_ni       (rst_shadow_n),
    .instr_valid_i(shadow_instr_valid),
    .instr_i      (shadow_instr),
    .wb_valid_o   (shadow_wb_valid),
    .wb_addr_o    (shadow_wb_addr),
    .wb_data_o    (shadow_wb_data)
  );

  ////////////////////////////////////////////////////////////////////
  // Main outputs, one cycle deeper for the shadow output register

  logic [lockstep_pkg::CORE_OUT_W-1:0] main_word;
  logic [lockstep_pkg::CORE_OUT_W-1:0] main_word_dly;
  logic [lockstep_pkg::CORE_OUT_W-1:0] shadow_word;

  assign main_word   = {main_wb_valid_i, main_wb_addr_i, main_wb_data_i};
  assign shadow_word = {shadow_wb_valid, shadow_wb_addr, shadow_wb_data};

  lockstep_delay #(
    .Width(lockstep_pkg::CORE_OUT_W),
    .Depth(lockstep_pkg::LOCKSTEP_OFFSET + 1)
  ) u_out_delay (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .data_i(main_word),
    .data_o(main_word_dly)
  );

  lockstep_compare u_compare (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmp_en_i     (cmp_en),
    .shadow_out_i (shadow_word),
    .main_out_i   (main_word_dly),
    .alert_major_o(alert_major_o)
  );

endmodule

`default_nettype wire

// ==== hdl/lockstep_compare.sv ====
/*
  Output register of the shadow core and the gated comparison
*/
`timescale 1ns/1ps
`default_nettype none

module lockstep_compare (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                cmp_en_i,
  input  logic [lockstep_pkg::CORE_OUT_W-1:0] shadow_out_i,
  input  logic [lockstep_pkg::CORE_OUT_W-1:0] main_out_i,
  output logic                                alert_major_o
);

  logic [lockstep_pkg::CORE_OUT_W-1:0] shadow_out_q;

  // One extra cycle on the shadow side, matched by the deeper output delay
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_out_q <= '0;
    end else begin
      shadow_out_q <= shadow_out_i;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Comparison

  logic outputs_differ;

  assign outputs_differ = (shadow_out_q != main_out_i);

  // Any differing bit raises the alert once comparison is enabled
  assign alert_major_o = cmp_en_i & outputs_differ;

endmodule

`default_nettype wire

// ==== hdl/mini_core.sv ====
/*
  Two-stage core with four 16-bit registers
  Decode and execute in stage one, write-back in stage two
*/
`timescale 1ns/1ps
`default_nettype none

module mini_core (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                instr_valid_i,
  input  logic [lockstep_pkg::INSTR_W-1:0]    instr_i,
  output logic                                wb_valid_o,
  output logic [lockstep_pkg::REG_ADDR_W-1:0] wb_addr_o,
  output logic [lockstep_pkg::XLEN-1:0]       wb_data_o
);

  ////////////////////////////////////////////////////////////////////
  // Stage one

  logic                 ex_valid_q;
  lockstep_pkg::instr_u ex_instr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex_valid_q <= 1'b0;
    end else begin
      ex_valid_q <= instr_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      ex_instr_q <= instr_i;
    end
  end

  logic [lockstep_pkg::XLEN-1:0]       rf_q [lockstep_pkg::NUM_REGS];
  logic                                wb_valid_q;
  logic [lockstep_pkg::REG_ADDR_W-1:0] wb_addr_q;
  logic [lockstep_pkg::XLEN-1:0]       wb_data_q;

  logic [lockstep_pkg::XLEN-1:0]       rs1_val;
  logic [lockstep_pkg::XLEN-1:0]       rs2_val;
  logic [lockstep_pkg::XLEN-1:0]       rd_val;
  logic [lockstep_pkg::XLEN-1:0]       imm_sext;
  logic [lockstep_pkg::XLEN-1:0]       imm_zext;

  // Operand reads, forwarded from the write-back stage
  assign rs1_val = (wb_valid_q && wb_addr_q == ex_instr_q.r.rs1) ? wb_data_q
                                                                 : rf_q[ex_instr_q.r.rs1];
  assign rs2_val = (wb_valid_q && wb_addr_q == ex_instr_q.r.rs2) ? wb_data_q
                                                                 : rf_q[ex_instr_q.r.rs2];
  assign rd_val  = (wb_valid_q && wb_addr_q == ex_instr_q.i.rd) ? wb_data_q
                                                                : rf_q[ex_instr_q.i.rd];

  assign imm_sext = {{(lockstep_pkg::XLEN - lockstep_pkg::IMM_W){ex_instr_q.i.imm[9]}},
                     ex_instr_q.i.imm};
  assign imm_zext = {{(lockstep_pkg::XLEN - lockstep_pkg::IMM_W){1'b0}}, ex_instr_q.i.imm};

  logic                                ex_wr_en;
  logic [lockstep_pkg::REG_ADDR_W-1:0] ex_wr_addr;
  logic [lockstep_pkg::XLEN-1:0]       ex_result;

  always_comb begin
    ex_wr_en  = 1'b0;
    ex_result = '0;
    if (ex_valid_q) begin
      ex_wr_en = 1'b1;
      case (ex_instr_q.r.opcode)
        lockstep_pkg::OP_ADD:  ex_result = rs1_val + rs2_val;
        lockstep_pkg::OP_SUB:  ex_result = rs1_val - rs2_val;
        lockstep_pkg::OP_XOR:  ex_result = rs1_val ^ rs2_val;
        lockstep_pkg::OP_AND:  ex_result = rs1_val & rs2_val;
        lockstep_pkg::OP_ADDI: ex_result = rd_val + imm_sext;
        lockstep_pkg::OP_LDI:  ex_result = imm_zext;
        default: begin
          // No-op, nothing written
          ex_wr_en = 1'b0;
        end
      endcase
    end
  end

  assign ex_wr_addr = ex_wr_en ? ex_instr_q.r.rd : '0;

  ////////////////////////////////////////////////////////////////////
  // Stage two

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_valid_q <= 1'b0;
      wb_addr_q  <= '0;
      wb_data_q  <= '0;
    end else begin
      wb_valid_q <= ex_wr_en;
      wb_addr_q  <= ex_wr_addr;
      wb_data_q  <= ex_result;
    end
  end

  // Registers start at zero to match the main core
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < lockstep_pkg::NUM_REGS; i++) begin
        rf_q[i] <= '0;
      end
    end else if (wb_valid_q) begin
      rf_q[wb_addr_q] <= wb_data_q;
    end
  end

  assign wb_valid_o = wb_valid_q;
  assign wb_addr_o  = wb_addr_q;
  assign wb_data_o  = wb_data_q;

endmodule

`default_nettype wire

// ==== hdl/shadow_rst_seq.sv ====
/*
  Reset sequencer of the shadow core
  Releases the shadow reset after the offset, then enables comparison
*/
`timescale 1ns/1ps
`default_nettype none

module shadow_rst_seq (
  input  logic clk_i,
  input  logic rst_ni,
  output logic rst_shadow_no,
  output logic cmp_en_o
);

  logic [lockstep_pkg::OFFSET_W-1:0] cnt_q;
  logic                              cnt_done;

  // Counter stops at its terminal value
  assign cnt_done = (cnt_q == lockstep_pkg::OFFSET_W'(lockstep_pkg::LOCKSTEP_OFFSET - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (!cnt_done) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Registered flag drives the shadow reset, glitch-free
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_shadow_no <= 1'b0;
      cmp_en_o      <= 1'b0;
    end else begin
      rst_shadow_no <= cnt_done;
      cmp_en_o      <= rst_shadow_no;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/lockstep_delay.sv ====
/*
  Shift-register delay line of Depth words
  Contents clear on reset
*/
`timescale 1ns/1ps
`default_nettype none

module lockstep_delay #(
  parameter int unsigned Width = 1,
  parameter int unsigned Depth = 1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [Width-1:0] data_i,
  output logic [Width-1:0] data_o
);

  logic [Depth-1:0][Width-1:0] stage_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= '0;
    end else begin
      stage_q[0] <= data_i;
      for (int unsigned i = 1; i < Depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // Oldest word leaves the line
  assign data_o = stage_q[Depth-1];

endmodule

`default_nettype wire

// ==== hdl/lockstep_pkg.sv ====
/*
  Shared constants of the lockstep checker and the mini core
  Opcode encodings and the instruction word union
*/
`default_nettype none

package lockstep_pkg;

  // Shadow core lag behind the main core, in cycles
  localparam int unsigned LOCKSTEP_OFFSET = 2;
  localparam int unsigned OFFSET_W = (LOCKSTEP_OFFSET > 1) ? $clog2(LOCKSTEP_OFFSET) : 1;

  localparam int unsigned XLEN       = 16;
  localparam int unsigned NUM_REGS   = 4;
  localparam int unsigned REG_ADDR_W = $clog2(NUM_REGS);
  localparam int unsigned INSTR_W    = 16;
  localparam int unsigned OPCODE_W   = 4;
  localparam int unsigned IMM_W      = 10;

  // Write-back valid, address and data packed into one word
  localparam int unsigned CORE_OUT_W = 1 + REG_ADDR_W + XLEN;

  // Register form
  localparam logic [OPCODE_W-1:0] OP_ADD  = 4'h1;
  localparam logic [OPCODE_W-1:0] OP_SUB  = 4'h2;
  localparam logic [OPCODE_W-1:0] OP_XOR  = 4'h3;
  localparam logic [OPCODE_W-1:0] OP_AND  = 4'h4;
  // Immediate form, anything else is a no-op
  localparam logic [OPCODE_W-1:0] OP_ADDI = 4'h5;
  localparam logic [OPCODE_W-1:0] OP_LDI  = 4'h6;

  typedef union packed {
    struct packed {
      logic [OPCODE_W-1:0]   opcode;
      logic [REG_ADDR_W-1:0] rd;
      logic [REG_ADDR_W-1:0] rs1;
      logic [REG_ADDR_W-1:0] rs2;
      logic [5:0]            unused;
    } r;
    struct packed {
      logic [OPCODE_W-1:0]   opcode;
      logic [REG_ADDR_W-1:0] rd;
      logic [IMM_W-1:0]      imm;
    } i;
  } instr_u;

endpackage

`default_nettype wire
